// ==== tb/issue_input.txt ====
# pc word refill invalid stall expected_slot delay_slot
# expected_slot 0 marks the entry left behind in the queue
bfc00000 00430821 0 0 0 1 0
bfc00004 00a62021 0 0 0 2 0
bfc00008 24080001 0 0 1 1 0
bfc0000c 25090002 0 0 0 1 0
bfc00010 8faa0000 0 0 0 2 0
bfc00014 8fab0004 0 0 0 1 0
bfc00018 afac0008 0 0 0 1 0
bfc0001c 00430018 0 0 0 2 0
bfc00020 00006812 0 0 0 1 0
bfc00024 00007810 0 0 0 1 0
bfc00028 00223821 0 0 0 2 0
bfc0002c 0c000100 0 0 0 1 0
bfc00030 00a62021 0 0 0 2 1
bfc00034 00a62021 0 0 0 1 0
bfc00038 10220004 0 0 0 1 0
bfc0003c 00430821 0 0 0 2 1
bfc00040 408e6000 0 0 0 1 0
bfc00044 00a62021 0 0 0 1 0
bfc00048 42000002 0 0 0 1 0
bfc0004c 00430821 0 0 1 1 0
bfc00050 00a62021 0 0 0 2 0
bfc00056 00430821 1 0 0 1 0
bfc00058 00a62021 0 1 0 2 0
bfc0005c 24080001 0 0 0 1 0
bfc00060 25090002 0 0 0 1 0
bfc00064 00000000 0 0 0 2 0
bfc00068 00000000 0 0 0 1 0
bfc0006c 00000000 0 0 0 2 0
bfc00070 00000000 0 0 0 0 0

// ==== compile.f ====
source/issue_pkg.sv
source/inst_queue.sv
source/inst_decoder.sv
source/dual_issue.sv
source/issue_perf_wb.sv
source/issue_stage_top.sv
tb/issue_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module issue_stage_tb -o sim

out=$(./obj_dir/sim)
echo "$out"

grep -q "^TEST PASS$" <<< "$out"

// ==== tb/issue_stage_tb.sv ====
`timescale 1ns/1ns

module issue_stage_tb;
    import issue_pkg::*;

    localparam int max_lines  = 64;
    localparam int clk_period = 100;

    logic          clk;
    logic          rst;
    logic          push_valid;
    fetch_pkt_t    push_pkt;
    logic          push_ready;
    logic          stall;
    logic          cls_refetch;
    issue_bundle_t slot_1;
    issue_bundle_t slot_2;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    logic [3:0]    wb_adr;
    word_t         wb_dat_o;
    logic          wb_ack;

    addr_t f_pc      [max_lines];
    word_t f_inst    [max_lines];
    logic  f_refill  [max_lines];
    logic  f_invalid [max_lines];
    logic  f_stall   [max_lines];
    int    f_slot    [max_lines];
    logic  f_ds      [max_lines];
    logic  stall_used[max_lines];

    int         n_lines;
    int         n_issue;
    int         exp_idx;
    int         push_idx;
    int         errors;
    int         cnt_1;
    int         cnt_2;
    int         refetch_age;
    logic       ref_model;
    logic       loaded;
    logic       running;
    logic       nxt_push_valid;
    fetch_pkt_t nxt_pkt;
    logic       nxt_stall;
    logic       nxt_cls;

    issue_stage_top issue_stage_top_i (
        .clk         (clk),
        .rst         (rst),
        .push_valid  (push_valid),
        .push_pkt    (push_pkt),
        .push_ready  (push_ready),
        .stall       (stall),
        .cls_refetch (cls_refetch),
        .slot_1      (slot_1),
        .slot_2      (slot_2),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_o    (wb_dat_o),
        .wb_ack      (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // reference classification of an instruction word
    function automatic logic word_is_jump(word_t w);
        return w[31:26] inside {6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07} ||
               (w[31:26] == 6'h00 && w[5:1] == 5'b00100);     // jr, jalr
    endfunction

    function automatic logic word_is_hilo(word_t w);
        return w[31:26] == 6'h00 &&
               w[5:0] inside {6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b};
    endfunction

    function automatic logic word_is_ls(word_t w);
        return w[31:26] inside {6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26,
                                6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e};
    endfunction

    // written register, zero when none
    function automatic logic [4:0] word_dest(word_t w);
        logic [5:0] op;
        op = w[31:26];
        if (w == '0) return 5'd0;
        if (op == 6'h00) begin
            if (w[5:0] inside {6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h09, 6'h10, 6'h12,
                               6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                               6'h2a, 6'h2b}) return w[15:11];
            return 5'd0;
        end
        if (op == 6'h01) return w[20] ? 5'd31 : 5'd0;
        if (op == 6'h03) return 5'd31;
        if (op inside {[6'h08:6'h0f], [6'h20:6'h26]}) return w[20:16];
        if (op == 6'h10 && w[25:21] == 5'd0) return w[20:16];   // mfc0
        return 5'd0;
    endfunction

    function automatic logic can_pair(word_t a, word_t b);
        logic [4:0] d;
        d = word_dest(a);
        if (d != 5'd0 && (d == b[25:21] || d == b[20:16])) return 1'b0;
        if (word_is_jump(a) || word_is_jump(b)) return !word_is_jump(b);
        if (word_is_hilo(a) || word_is_hilo(b)) return word_is_hilo(a) ^ word_is_hilo(b);
        if (a[31:26] == 6'h10 || b[31:26] == 6'h10) return 1'b0;
        if (word_is_ls(a) || word_is_ls(b)) return word_is_ls(a) ^ word_is_ls(b);
        return 1'b1;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic load_input();
        int    fd;
        int    pc;
        int    w;
        int    rf;
        int    iv;
        int    st;
        int    sl;
        int    ds;
        string line;
        n_lines = 0;
        fd = $fopen("tb/issue_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/issue_input.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_lines < max_lines) begin
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%h %h %d %d %d %d %d", pc, w, rf, iv, st, sl, ds) == 7) begin
                    f_pc[n_lines]       = addr_t'(pc);
                    f_inst[n_lines]     = word_t'(w);
                    f_refill[n_lines]   = rf[0];
                    f_invalid[n_lines]  = iv[0];
                    f_stall[n_lines]    = st[0];
                    f_slot[n_lines]     = sl;
                    f_ds[n_lines]       = ds[0];
                    stall_used[n_lines] = 1'b0;
                    n_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    // replay the pairing rules over the file and confirm its expectations
    task automatic check_file();
        int   i;
        logic p;
        i = 0;
        n_issue = 0;
        while (i + 1 < n_lines) begin
            p = can_pair(f_inst[i], f_inst[i + 1]);
            check_val($sformatf("file slot line %0d", i), f_slot[i], 1);
            check_val($sformatf("file ds line %0d", i), 32'(f_ds[i]), 0);
            n_issue++;
            if (p) begin
                check_val($sformatf("file slot line %0d", i + 1), f_slot[i + 1], 2);
                check_val($sformatf("file ds line %0d", i + 1), 32'(f_ds[i + 1]),
                          32'(word_is_jump(f_inst[i])));
                n_issue++;
                i += 2;
            end else begin
                i += 1;
            end
        end
        for (int k = i; k < n_lines; k++) begin
            check_val($sformatf("file slot line %0d", k), f_slot[k], 0);
        end
    endtask

    task automatic check_bundle(issue_bundle_t b, int idx, int slot_no, logic exp_ref);
        string s;
        s = $sformatf("slot_%0d line %0d", slot_no, idx);
        check_val({s, " pc"}, b.pc, f_pc[idx]);
        check_val({s, " inst"}, b.inst, f_inst[idx]);
        check_val({s, " slot"}, slot_no, f_slot[idx]);
        check_val({s, " in_delay_slot"}, 32'(b.in_delay_slot), 32'(f_ds[idx]));
        check_val({s, " inst_adel"}, 32'(b.inst_adel), 32'(f_pc[idx][1:0] != 2'b00));
        check_val({s, " refill"}, 32'(b.refill), 32'(f_refill[idx]));
        check_val({s, " invalid"}, 32'(b.invalid), 32'(f_invalid[idx]));
        check_val({s, " refetch"}, 32'(b.refetch), 32'(exp_ref));
        check_val({s, " dec.w_reg_dst"}, 32'(b.dec.w_reg_ena ? b.dec.w_reg_dst : 5'd0),
                  32'(word_dest(f_inst[idx])));
    endtask

    task automatic wb_read(logic [3:0] adr, output word_t data);
        int waited;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        waited = 0;
        @(negedge clk);
        while (!wb_ack && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        assert (wb_ack) else begin
            $display("wishbone read at %h got no ack", adr);
            errors++;
        end
        data = wb_dat_o;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // outputs are sampled mid cycle, next inputs prepared for the rising edge
    always @(negedge clk) begin
        logic tlb_issued;
        if (running) begin
            tlb_issued = 1'b0;
            check_val("push_ready", 32'(push_ready),
                      32'((push_idx - exp_idx) < queue_depth));
            if (stall) begin
                assert (!slot_1.valid && !slot_2.valid) else begin
                    $display("[ERROR] valid during stall: slot_1.valid %h slot_2.valid %h",
                             slot_1.valid, slot_2.valid);
                    errors++;
                end
            end
            assert (!slot_2.valid || slot_1.valid) else begin
                $display("slot 2 issued without slot 1");
                errors++;
            end
            if (slot_1.valid) begin
                if (exp_idx < n_issue) begin
                    check_bundle(slot_1, exp_idx, 1, ref_model);
                end else begin
                    $display("slot 1 issued past the last expected line");
                    errors++;
                end
                tlb_issued = tlb_issued || slot_1.inst inside {32'h42000001, 32'h42000002};
                exp_idx++;
                cnt_1++;
            end
            if (slot_2.valid) begin
                if (exp_idx < n_issue) begin
                    check_bundle(slot_2, exp_idx, 2, ref_model);
                end else begin
                    $display("slot 2 issued past the last expected line");
                    errors++;
                end
                tlb_issued = tlb_issued || slot_2.inst inside {32'h42000001, 32'h42000002};
                exp_idx++;
                cnt_2++;
            end

            if (ref_model) ref_model = !cls_refetch;
            else           ref_model = tlb_issued;
            // counted in issue cycles, so some bundles see refetch high
            if (!ref_model || cls_refetch) refetch_age = 0;
            else if (slot_1.valid)         refetch_age++;
            nxt_cls = refetch_age == 3;     // memory stage answers a bit later

            if (push_valid && push_ready) push_idx++;
            nxt_push_valid = push_idx < n_lines && $urandom_range(3, 0) != 0;
            if (push_idx < n_lines) begin
                nxt_pkt.refill  = f_refill[push_idx];
                nxt_pkt.invalid = f_invalid[push_idx];
                nxt_pkt.pc      = f_pc[push_idx];
                nxt_pkt.inst    = f_inst[push_idx];
            end

            nxt_stall = 1'b0;
            if (exp_idx < n_lines && f_stall[exp_idx] && !stall_used[exp_idx]) begin
                nxt_stall = 1'b1;
                stall_used[exp_idx] = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (running) begin
            push_valid  <= nxt_push_valid;
            push_pkt    <= nxt_pkt;
            stall       <= nxt_stall;
            cls_refetch <= nxt_cls;
        end
    end

    initial begin
        longint limit;
        wait (loaded);
        limit = longint'(40 * n_lines + 200) * clk_period;
        #(limit);
        $display("timeout after %0d cycles, %0d of %0d lines issued",
                 40 * n_lines + 200, exp_idx, n_issue);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        word_t rd_data;
        rst            = 1'b1;
        push_valid     = 1'b0;
        push_pkt       = '0;
        stall          = 1'b0;
        cls_refetch    = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        nxt_push_valid = 1'b0;
        nxt_pkt        = '0;
        nxt_stall      = 1'b0;
        nxt_cls        = 1'b0;
        errors         = 0;
        exp_idx        = 0;
        push_idx       = 0;
        cnt_1          = 0;
        cnt_2          = 0;
        refetch_age    = 0;
        ref_model      = 1'b0;
        running        = 1'b0;
        loaded         = 1'b0;
        void'($urandom(32'hfa0253dd));

        load_input();
        check_file();
        loaded = 1'b1;

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        running = 1'b1;     // first sampling on the following falling edge

        wait (exp_idx >= n_issue);
        repeat (4) @(posedge clk);

        wb_read(4'h0, rd_data);
        check_val("wb_dat_o slot 1 count", rd_data, word_t'(cnt_1));
        wb_read(4'h4, rd_data);
        check_val("wb_dat_o slot 2 count", rd_data, word_t'(cnt_2));
        wb_read(4'h8, rd_data);
        check_val("wb_dat_o unmapped", rd_data, 32'h0);
        repeat (2) @(posedge clk);

        $display("errors %0d, slot 1 issues %0d, slot 2 issues %0d, lines %0d",
                 errors, cnt_1, cnt_2, n_lines);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== source/issue_stage_top.sv ====
`timescale 1ns/1ns

module issue_stage_top (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     push_valid,
    input  issue_pkg::fetch_pkt_t    push_pkt,
    output logic                     push_ready,

    input  logic                     stall,
    input  logic                     cls_refetch,

    output issue_pkg::issue_bundle_t slot_1,
    output issue_pkg::issue_bundle_t slot_2,

    // perf counter port
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [3:0]               wb_adr,
    output issue_pkg::word_t         wb_dat_o,
    output logic                     wb_ack
);
    import issue_pkg::*;

    fetch_pkt_t head_1;
    fetch_pkt_t head_2;
    queue_cnt_t head_cnt;
    logic       pop_1;
    logic       pop_2;

    inst_queue inst_queue_i (
        .clk        (clk),
        .rst        (rst),
        .push_valid (push_valid),
        .push_pkt   (push_pkt),
        .push_ready (push_ready),
        .pop_1      (pop_1),
        .pop_2      (pop_2),
        .head_1     (head_1),
        .head_2     (head_2),
        .head_cnt   (head_cnt)
    );

    dual_issue dual_issue_i (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .cls_refetch (cls_refetch),
        .head_1      (head_1),
        .head_2      (head_2),
        .head_cnt    (head_cnt),
        .pop_1       (pop_1),
        .pop_2       (pop_2),
        .slot_1      (slot_1),
        .slot_2      (slot_2)
    );

    issue_perf_wb issue_perf_wb_i (
        .clk      (clk),
        .rst      (rst),
        .issue_1  (slot_1.valid),
        .issue_2  (slot_2.valid),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack)
    );

endmodule

// ==== source/issue_perf_wb.sv ====
`timescale 1ns/1ns

module issue_perf_wb (
    input  logic             clk,
    input  logic             rst,

    input  logic             issue_1,
    input  logic             issue_2,

    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [3:0]       wb_adr,
    output issue_pkg::word_t wb_dat_o,
    output logic             wb_ack
);
    import issue_pkg::*;

    word_t cnt_1;
    word_t cnt_2;
    logic  req;

    assign req = wb_cyc && wb_stb && !wb_ack;   // idle cycle after each ack

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_1 <= '0;
            cnt_2 <= '0;
        end else begin
            if (issue_1) cnt_1 <= cnt_1 + word_t'(1);
            if (issue_2) cnt_2 <= cnt_2 + word_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (wb_we) begin
                wb_dat_o <= '0;     // read only, writes just acked
            end else begin
                case (wb_adr)
                    wb_adr_cnt_1: wb_dat_o <= cnt_1;
                    wb_adr_cnt_2: wb_dat_o <= cnt_2;
                    default:      wb_dat_o <= '0;
                endcase
            end
        end
    end

    a_ack_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack
    );

endmodule

// ==== source/dual_issue.sv ====
`timescale 1ns/1ns

module dual_issue (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     stall,
    input  logic                     cls_refetch,   // from mem stage

    input  issue_pkg::fetch_pkt_t    head_1,
    input  issue_pkg::fetch_pkt_t    head_2,
    input  issue_pkg::queue_cnt_t    head_cnt,

    output logic                     pop_1,
    output logic                     pop_2,

    output issue_pkg::issue_bundle_t slot_1,
    output issue_pkg::issue_bundle_t slot_2
);
    import issue_pkg::*;

    decoded_t dec_1;
    decoded_t dec_2;
    logic     raw_conflict;
    logic     pair_ok;
    logic     tlb_write_issued;
    logic     refetch;

    inst_decoder dec_1_i (
        .inst (head_1.inst),
        .dec  (dec_1)
    );

    inst_decoder dec_2_i (
        .inst (head_2.inst),
        .dec  (dec_2)
    );

    // w_reg_ena is already low for r0
    assign raw_conflict = dec_1.w_reg_ena &&
                          (dec_1.w_reg_dst == dec_2.rs || dec_1.w_reg_dst == dec_2.rt);

    always_comb begin
        if (raw_conflict) begin
            pair_ok = 1'b0;
        end else if (dec_1.is_jump || dec_2.is_jump) begin
            pair_ok = !dec_2.is_jump;   // jump in slot 1 takes its delay slot
        end else if (dec_1.is_hilo || dec_2.is_hilo) begin
            pair_ok = dec_1.is_hilo ^ dec_2.is_hilo;
        end else if (dec_1.is_cop0 || dec_2.is_cop0) begin
            pair_ok = 1'b0;
        end else if (dec_1.is_ls || dec_2.is_ls) begin
            pair_ok = dec_1.is_ls ^ dec_2.is_ls;
        end else begin
            pair_ok = 1'b1;
        end
    end

    // need two entries so a delay slot is always visible
    assign pop_1 = !stall && head_cnt >= queue_cnt_t'(2);
    assign pop_2 = pop_1 && pair_ok;

    assign tlb_write_issued = (pop_1 && (dec_1.is_tlbr || dec_1.is_tlbwi)) ||
                              (pop_2 && (dec_2.is_tlbr || dec_2.is_tlbwi));

    always_ff @(posedge clk) begin
        if (rst) begin
            refetch <= 1'b0;
        end else if (refetch) begin
            refetch <= !cls_refetch;
        end else begin
            refetch <= tlb_write_issued;
        end
    end

    always_comb begin
        slot_1.valid         = pop_1;
        slot_1.pc            = head_1.pc;
        slot_1.inst          = head_1.inst;
        slot_1.dec           = dec_1;
        slot_1.in_delay_slot = 1'b0;
        slot_1.inst_adel     = head_1.pc[1:0] != 2'b00;
        slot_1.refill        = head_1.refill;
        slot_1.invalid       = head_1.invalid;
        slot_1.refetch       = refetch;

        slot_2.valid         = pop_2;
        slot_2.pc            = head_2.pc;
        slot_2.inst          = head_2.inst;
        slot_2.dec           = dec_2;
        slot_2.in_delay_slot = dec_1.is_jump;
        slot_2.inst_adel     = head_2.pc[1:0] != 2'b00;
        slot_2.refill        = head_2.refill;
        slot_2.invalid       = head_2.invalid;
        slot_2.refetch       = refetch;
    end

    // slot 2 never runs alone and never holds a jump
    a_slot_2_needs_slot_1: assert property (
        @(posedge clk) disable iff (rst)
        slot_2.valid |-> slot_1.valid && !slot_2.dec.is_jump
    );

endmodule

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ns

module inst_decoder (
    input  issue_pkg::word_t    inst,
    output issue_pkg::decoded_t dec
);
    import issue_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    op_kind_e   kind;
    reg_idx_t   dst;
    logic       has_dst;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];

    always_comb begin
        kind = illegal;
        case (opcode)
            op_special: begin
                case (funct)
                    6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07: kind = shift;
                    6'h08, 6'h09:                             kind = jump_reg;
                    6'h10, 6'h12:                             kind = mfhilo;
                    // mthi/mtlo grouped with mult, both write hi/lo
                    6'h11, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b: kind = mult;
                    6'h20, 6'h21, 6'h22, 6'h23,
                    6'h24, 6'h25, 6'h26, 6'h27,
                    6'h2a, 6'h2b:                             kind = alu_r;
                    default:                                  kind = illegal;
                endcase
            end
            op_regimm, 6'h04, 6'h05, 6'h06, 6'h07: kind = branch;
            op_j, op_jal:                          kind = jump_imm;
            6'h08, 6'h09, 6'h0a, 6'h0b,
            6'h0c, 6'h0d, 6'h0e:                   kind = alu_i;
            op_lui:                                kind = lui;
            6'h20, 6'h21, 6'h22, 6'h23,
            6'h24, 6'h25, 6'h26:                   kind = load;
            6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e:     kind = store;
            op_cop0: begin
                if (inst[25]) begin     // CO bit, tlb ops
                    case (funct)
                        fn_tlbr:  kind = tlbr;
                        fn_tlbwi: kind = tlbwi;
                        fn_tlbp:  kind = tlbp;
                        default:  kind = illegal;
                    endcase
                end else if (inst[25:21] == cop0_rs_mf) begin
                    kind = mfc0;
                end else if (inst[25:21] == cop0_rs_mt) begin
                    kind = mtc0;
                end
            end
            default: kind = illegal;
        endcase
        if (inst == '0) begin
            kind = nop;
        end
    end

    always_comb begin
        dst     = '0;
        has_dst = 1'b0;
        case (kind)
            alu_r, shift, mfhilo: begin
                dst     = inst[15:11];
                has_dst = 1'b1;
            end
            jump_reg: begin
                dst     = inst[15:11];
                has_dst = funct[0];     // jalr only
            end
            alu_i, lui, load, mfc0: begin
                dst     = inst[20:16];
                has_dst = 1'b1;
            end
            jump_imm: begin
                dst     = link_reg;
                has_dst = opcode == op_jal;
            end
            branch: begin
                dst     = link_reg;
                has_dst = opcode == op_regimm && inst[20];  // bltzal/bgezal
            end
            default: begin
                dst     = '0;
                has_dst = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec.kind      = kind;
        dec.rs        = inst[25:21];
        dec.rt        = inst[20:16];
        dec.rd        = inst[15:11];
        dec.sa        = inst[10:6];
        dec.w_reg_ena = has_dst && dst != '0;   // r0 writes dropped
        dec.w_reg_dst = dst;
        dec.imme      = inst[15:0];
        dec.j_imme    = inst[25:0];
        dec.is_jump   = kind inside {branch, jump_imm, jump_reg};
        dec.is_ls     = kind inside {load, store};
        dec.is_hilo   = kind inside {mult, mfhilo};
        dec.is_cop0   = kind inside {mfc0, mtc0, tlbp, tlbr, tlbwi};
        dec.is_tlbp   = kind == tlbp;
        dec.is_tlbr   = kind == tlbr;
        dec.is_tlbwi  = kind == tlbwi;
    end

endmodule

// ==== source/inst_queue.sv ====
`timescale 1ns/1ns

module inst_queue (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  push_valid,
    input  issue_pkg::fetch_pkt_t push_pkt,
    output logic                  push_ready,

    input  logic                  pop_1,
    input  logic                  pop_2,

    output issue_pkg::fetch_pkt_t head_1,
    output issue_pkg::fetch_pkt_t head_2,
    output issue_pkg::queue_cnt_t head_cnt
);
    import issue_pkg::*;

    fetch_pkt_t mem [queue_depth];

    queue_ptr_t rd_ptr;
    queue_ptr_t rd_ptr_2;   // second oldest entry
    queue_ptr_t wr_ptr;
    queue_cnt_t cnt;
    queue_cnt_t pop_num;
    logic       push_fire;

    assign push_ready = cnt < queue_cnt_t'(queue_depth);
    assign push_fire  = push_valid && push_ready;
    assign pop_num    = queue_cnt_t'(pop_1) + queue_cnt_t'(pop_2);

    assign rd_ptr_2 = rd_ptr + queue_ptr_t'(1);

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + queue_ptr_t'(1);
            end
            rd_ptr <= rd_ptr + queue_ptr_t'(pop_num);
            cnt    <= cnt + queue_cnt_t'(push_fire) - pop_num;
        end
    end

    assign head_1   = mem[rd_ptr];
    assign head_2   = mem[rd_ptr_2];
    assign head_cnt = cnt;

    // a full queue must not move its write side
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        cnt == queue_cnt_t'(queue_depth) |=> wr_ptr == $past(wr_ptr)
    );

    // issue side never pops entries that are not there
    a_pop_within_cnt: assert property (
        @(posedge clk) disable iff (rst)
        pop_num <= cnt
    );

endmodule

// ==== source/issue_pkg.sv ====
package issue_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;    // also counter and wishbone data width
    typedef logic [4:0]  reg_idx_t;

    localparam int queue_depth = 8;

    typedef logic [2:0] queue_ptr_t;
    typedef logic [3:0] queue_cnt_t;

    // major opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_cop0    = 6'h10;

    // cop0 sub-decode
    localparam logic [4:0] cop0_rs_mf = 5'h00;
    localparam logic [4:0] cop0_rs_mt = 5'h04;
    localparam logic [5:0] fn_tlbr    = 6'h01;
    localparam logic [5:0] fn_tlbwi   = 6'h02;
    localparam logic [5:0] fn_tlbp    = 6'h08;

    localparam reg_idx_t link_reg = 5'd31;

    // counter port map
    localparam logic [3:0] wb_adr_cnt_1 = 4'h0;
    localparam logic [3:0] wb_adr_cnt_2 = 4'h4;

    typedef enum logic [4:0] {
        alu_r, alu_i, shift, lui,
        load, store,
        branch, jump_imm, jump_reg,
        mult, mfhilo,
        mfc0, mtc0,
        tlbp, tlbr, tlbwi,
        nop, illegal
    } op_kind_e;

    // same bit layout as the fetch fifo word
    typedef struct packed {
        logic  refill;
        logic  invalid;
        addr_t pc;
        word_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        op_kind_e    kind;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        reg_idx_t    sa;
        logic        w_reg_ena;
        reg_idx_t    w_reg_dst;
        logic [15:0] imme;
        logic [25:0] j_imme;
        logic        is_jump;
        logic        is_ls;
        logic        is_hilo;
        logic        is_cop0;   // covers the tlb ops too
        logic        is_tlbp;
        logic        is_tlbr;
        logic        is_tlbwi;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        word_t    inst;
        decoded_t dec;
        logic     in_delay_slot;
        logic     inst_adel;
        logic     refill;
        logic     invalid;
        logic     refetch;
    } issue_bundle_t;

endpackage
